// ==== hdl/common_pkg.sv ====
// Core-wide data word, byte address and decoded opcode types, referenced by scoped name
package common_pkg;

    // One machine word on the data path
    typedef logic [31:0] word_t;

    // Byte address produced by the AGU
    typedef logic [31:0] vaddr_t;

    // Memory opcodes as delivered by the decode stage
    typedef enum logic [3:0] {
        NOP = 4'd0,
        LB  = 4'd1,
        LBU = 4'd2,
        LH  = 4'd3,
        LHU = 4'd4,
        LW  = 4'd5,
        SB  = 4'd6,
        SH  = 4'd7,
        SW  = 4'd8
    } decoded_op_t;

    // True for the opcodes that write memory
    function automatic logic is_store(input decoded_op_t op);
        is_store = (op == SB) || (op == SH) || (op == SW);
    endfunction

endpackage

// ==== hdl/mem_pkg.sv ====
// Memory-side types for the load/store path: lane view of a word, enables and load tag
package mem_pkg;

    // One word seen either whole or as four byte lanes
    typedef union packed {
        common_pkg::word_t word;
        logic [3:0][7:0]   bytes;
    } mem_word_u;

    // One enable per byte lane, bit 0 is the lowest address
    typedef logic [3:0] byte_en_t;

    // Travels with a read so the result can be extracted and extended
    typedef struct packed {
        common_pkg::decoded_op_t op;
        logic [1:0]              offset;
    } load_tag_t;

endpackage

// ==== hdl/writedata.sv ====
// Store alignment: moves store data into its byte lanes and raises the matching enables
`timescale 1ns/1ps

module writedata (
    input  logic [1:0]              addr,
    input  common_pkg::decoded_op_t op,
    input  common_pkg::word_t       wd_raw,
    output common_pkg::word_t       wd,
    output mem_pkg::byte_en_t       be
);

    mem_pkg::mem_word_u lanes;

    always_comb begin
        lanes.word = '0;
        be         = '0;
        case (op)
            common_pkg::SW: begin
                lanes.word = wd_raw;
                be         = 4'b1111;
            end
            common_pkg::SH: begin
                // Half goes to lanes 0-1 or 2-3
                lanes.bytes[{addr[1], 1'b0}] = wd_raw[7:0];
                lanes.bytes[{addr[1], 1'b1}] = wd_raw[15:8];
                be = addr[1] ? 4'b1100 : 4'b0011;
            end
            common_pkg::SB: begin
                lanes.bytes[addr] = wd_raw[7:0];
                be                = 4'b0001 << addr;
            end
            default: begin
                // Loads and NOP write nothing
                lanes.word = '0;
                be         = '0;
            end
        endcase
    end

    assign wd = lanes.word;

endmodule

// ==== hdl/agu.sv ====
// Address generation stage: adds the operands and registers one queue entry per request
`timescale 1ns/1ps

module agu (
    input  logic                    clk,
    input  logic                    resetn,
    input  logic                    req_valid,
    input  common_pkg::decoded_op_t op,
    input  common_pkg::word_t       src1,
    input  common_pkg::word_t       src2,
    input  common_pkg::word_t       store_data,
    output logic                    ent_valid,
    output common_pkg::vaddr_t      ent_addr,
    output logic                    ent_we,
    output mem_pkg::byte_en_t       ent_be,
    output common_pkg::word_t       ent_wdata,
    output mem_pkg::load_tag_t      ent_tag
);

    common_pkg::vaddr_t sum;
    common_pkg::word_t  aligned;
    mem_pkg::byte_en_t  lane_en;

    assign sum = src1 + src2;

    writedata u_writedata (
        .addr   (sum[1:0]),
        .op     (op),
        .wd_raw (store_data),
        .wd     (aligned),
        .be     (lane_en)
    );

    always_ff @(posedge clk) begin
        if (!resetn) begin
            ent_valid <= 1'b0;
        end else begin
            ent_valid <= req_valid;
        end
    end

    // Entry payload, qualified by ent_valid
    always_ff @(posedge clk) begin
        if (req_valid) begin
            ent_addr       <= sum;
            ent_we         <= common_pkg::is_store(op);
            ent_be         <= lane_en;
            ent_wdata      <= aligned;
            ent_tag.op     <= op;
            ent_tag.offset <= sum[1:0];
        end
    end

endmodule

// ==== hdl/lsu_queue.sv ====
// In-order request queue: pops stores freely, pops loads against response credits
`timescale 1ns/1ps

module lsu_queue #(
    parameter int QUEUE_DEPTH = 4
) (
    input  logic               clk,
    input  logic               resetn,
    input  logic               ent_valid,
    input  common_pkg::vaddr_t ent_addr,
    input  logic               ent_we,
    input  mem_pkg::byte_en_t  ent_be,
    input  common_pkg::word_t  ent_wdata,
    input  mem_pkg::load_tag_t ent_tag,
    input  logic               resp_credit,
    output logic               issue_credit,
    output logic               mem_en,
    output logic               mem_we,
    output mem_pkg::byte_en_t  mem_be,
    output common_pkg::vaddr_t mem_addr,
    output common_pkg::word_t  mem_wdata,
    output mem_pkg::load_tag_t mem_tag
);

    localparam int PTR_W = (QUEUE_DEPTH > 1) ? $clog2(QUEUE_DEPTH) : 1;
    localparam int CNT_W = $clog2(QUEUE_DEPTH + 1);
    localparam int CRD_W = 8;

    common_pkg::vaddr_t addr_q  [QUEUE_DEPTH];
    logic               we_q    [QUEUE_DEPTH];
    mem_pkg::byte_en_t  be_q    [QUEUE_DEPTH];
    common_pkg::word_t  wdata_q [QUEUE_DEPTH];
    mem_pkg::load_tag_t tag_q   [QUEUE_DEPTH];

    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    logic [CNT_W-1:0] count;
    logic [CRD_W-1:0] resp_cnt;
    logic             pop;
    logic             load_pop;

    function automatic logic [PTR_W-1:0] next_ptr(input logic [PTR_W-1:0] ptr);
        next_ptr = (ptr == PTR_W'(QUEUE_DEPTH - 1)) ? '0 : ptr + 1'b1;
    endfunction

    // Loads need a response slot, stores do not
    assign pop      = (count != '0) && (we_q[rd_ptr] || (resp_cnt != '0));
    assign load_pop = pop && !we_q[rd_ptr];

    assign issue_credit = pop;
    assign mem_en       = pop;
    assign mem_we       = we_q[rd_ptr];
    assign mem_be       = be_q[rd_ptr];
    assign mem_addr     = addr_q[rd_ptr];
    assign mem_wdata    = wdata_q[rd_ptr];
    assign mem_tag      = tag_q[rd_ptr];

    always_ff @(posedge clk) begin
        if (!resetn) begin
            wr_ptr   <= '0;
            rd_ptr   <= '0;
            count    <= '0;
            resp_cnt <= '0;
        end else begin
            if (ent_valid) begin
                wr_ptr <= next_ptr(wr_ptr);
            end
            if (pop) begin
                rd_ptr <= next_ptr(rd_ptr);
            end
            count    <= count + CNT_W'(ent_valid) - CNT_W'(pop);
            resp_cnt <= resp_cnt + CRD_W'(resp_credit) - CRD_W'(load_pop);
        end
    end

    always_ff @(posedge clk) begin
        if (ent_valid) begin
            addr_q[wr_ptr]  <= ent_addr;
            we_q[wr_ptr]    <= ent_we;
            be_q[wr_ptr]    <= ent_be;
            wdata_q[wr_ptr] <= ent_wdata;
            tag_q[wr_ptr]   <= ent_tag;
        end
    end

endmodule

// ==== hdl/dmem.sv ====
// Word-organized data memory with byte-enabled writes and a one-cycle tagged read
`timescale 1ns/1ps

module dmem #(
    parameter int MEM_WORDS = 256
) (
    input  logic               clk,
    input  logic               resetn,
    input  logic               en,
    input  logic               we,
    input  mem_pkg::byte_en_t  be,
    input  common_pkg::vaddr_t addr,
    input  common_pkg::word_t  wdata,
    input  mem_pkg::load_tag_t tag_in,
    output logic               rvalid,
    output common_pkg::word_t  rdata,
    output mem_pkg::load_tag_t tag_out
);

    localparam int AW = $clog2(MEM_WORDS);

    logic [3:0][7:0] mem [MEM_WORDS];
    logic [AW-1:0]   idx;

    // Byte offset bits dropped
    assign idx = addr[AW+1:2];

    always_ff @(posedge clk) begin
        if (!resetn) begin
            for (int w = 0; w < MEM_WORDS; w++) begin
                mem[w] <= '0;
            end
            rvalid <= 1'b0;
        end else begin
            rvalid <= en && !we;
            if (en && we) begin
                for (int b = 0; b < 4; b++) begin
                    if (be[b]) begin
                        mem[idx][b] <= wdata[8*b +: 8];
                    end
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (en && !we) begin
            rdata   <= mem[idx];
            tag_out <= tag_in;
        end
    end

endmodule

// ==== hdl/readdata.sv ====
// Load result formatting: picks the addressed byte or half and sign- or zero-extends it
`timescale 1ns/1ps

module readdata (
    input  common_pkg::word_t  rd_raw,
    input  mem_pkg::load_tag_t tag,
    output common_pkg::word_t  rd
);

    mem_pkg::mem_word_u lanes;
    logic [7:0]         byte_sel;
    logic [15:0]        half_sel;

    assign lanes.word = rd_raw;
    assign byte_sel   = lanes.bytes[tag.offset];

    // Offset bit 0 ignored for halves
    assign half_sel = {lanes.bytes[{tag.offset[1], 1'b1}],
                       lanes.bytes[{tag.offset[1], 1'b0}]};

    always_comb begin
        case (tag.op)
            common_pkg::LB: begin
                rd = {{24{byte_sel[7]}}, byte_sel};
            end
            common_pkg::LBU: begin
                rd = {24'b0, byte_sel};
            end
            common_pkg::LH: begin
                rd = {{16{half_sel[15]}}, half_sel};
            end
            common_pkg::LHU: begin
                rd = {16'b0, half_sel};
            end
            default: begin
                // LW, whole word
                rd = lanes.word;
            end
        endcase
    end

endmodule

// ==== hdl/lsu_top.sv ====
// Load/store unit top: AGU, request queue, data memory and load formatting in series
`timescale 1ns/1ps

module lsu_top #(
    parameter int QUEUE_DEPTH = 4,
    parameter int MEM_WORDS   = 256
) (
    input  logic                    clk,
    input  logic                    resetn,
    input  logic                    req_valid,
    input  common_pkg::decoded_op_t op,
    input  common_pkg::word_t       src1,
    input  common_pkg::word_t       src2,
    input  common_pkg::word_t       store_data,
    output logic                    issue_credit,
    input  logic                    resp_credit,
    output logic                    resp_valid,
    output common_pkg::word_t       load_data
);

    logic               ent_valid;
    common_pkg::vaddr_t ent_addr;
    logic               ent_we;
    mem_pkg::byte_en_t  ent_be;
    common_pkg::word_t  ent_wdata;
    mem_pkg::load_tag_t ent_tag;

    logic               mem_en;
    logic               mem_we;
    mem_pkg::byte_en_t  mem_be;
    common_pkg::vaddr_t mem_addr;
    common_pkg::word_t  mem_wdata;
    mem_pkg::load_tag_t mem_tag;

    common_pkg::word_t  rdata;
    mem_pkg::load_tag_t rtag;

    agu u_agu (
        .clk        (clk),
        .resetn     (resetn),
        .req_valid  (req_valid),
        .op         (op),
        .src1       (src1),
        .src2       (src2),
        .store_data (store_data),
        .ent_valid  (ent_valid),
        .ent_addr   (ent_addr),
        .ent_we     (ent_we),
        .ent_be     (ent_be),
        .ent_wdata  (ent_wdata),
        .ent_tag    (ent_tag)
    );

    lsu_queue #(
        .QUEUE_DEPTH (QUEUE_DEPTH)
    ) u_lsu_queue (
        .clk          (clk),
        .resetn       (resetn),
        .ent_valid    (ent_valid),
        .ent_addr     (ent_addr),
        .ent_we       (ent_we),
        .ent_be       (ent_be),
        .ent_wdata    (ent_wdata),
        .ent_tag      (ent_tag),
        .resp_credit  (resp_credit),
        .issue_credit (issue_credit),
        .mem_en       (mem_en),
        .mem_we       (mem_we),
        .mem_be       (mem_be),
        .mem_addr     (mem_addr),
        .mem_wdata    (mem_wdata),
        .mem_tag      (mem_tag)
    );

    dmem #(
        .MEM_WORDS (MEM_WORDS)
    ) u_dmem (
        .clk     (clk),
        .resetn  (resetn),
        .en      (mem_en),
        .we      (mem_we),
        .be      (mem_be),
        .addr    (mem_addr),
        .wdata   (mem_wdata),
        .tag_in  (mem_tag),
        .rvalid  (resp_valid),
        .rdata   (rdata),
        .tag_out (rtag)
    );

    readdata u_readdata (
        .rd_raw (rdata),
        .tag    (rtag),
        .rd     (load_data)
    );

endmodule

// ==== bench/clk_gen.sv ====
// Clock and synchronous reset source for the LSU testbench, 40 ns period
`timescale 1ns/1ps

module clk_gen (
    output logic clk,
    output logic resetn
);

    initial begin
        clk = 1'b0;
        forever begin
            #20 clk = ~clk;
        end
    end

    // Low across the first two rising edges
    initial begin
        resetn = 1'b0;
        repeat (2) @(posedge clk);
        resetn <= 1'b1;
    end

endmodule

// ==== bench/lsu_sva.sv ====
// Concurrent checks on queue credits and load response timing, bound into the LSU top level
`timescale 1ns/1ps

module lsu_sva (
    input logic clk,
    input logic resetn,
    input logic ent_valid,
    input logic resp_credit,
    input logic issue_credit,
    input logic mem_en,
    input logic mem_we,
    input logic rvalid
);

    logic load_pop;
    int   entries;
    int   credits;

    assign load_pop = mem_en && !mem_we;

    // Occupancy and response credits as seen at the queue boundary
    always_ff @(posedge clk) begin
        if (!resetn) begin
            entries <= 0;
            credits <= 0;
        end else begin
            entries <= entries + int'(ent_valid) - int'(issue_credit);
            credits <= credits + int'(resp_credit) - int'(load_pop);
        end
    end

    credit_needs_entry: assert property (@(posedge clk) disable iff (!resetn)
        issue_credit |-> (entries > 0))
        else $error("issue credit returned while the queue was empty");

    load_needs_credit: assert property (@(posedge clk) disable iff (!resetn)
        load_pop |-> (credits > 0))
        else $error("load popped with no response credit held");

    // Read data one cycle after the pop, and never otherwise
    rvalid_after_pop: assert property (@(posedge clk) disable iff (!resetn)
        load_pop |=> rvalid)
        else $error("rvalid missing one cycle after a load pop");

    rvalid_only_after_pop: assert property (@(posedge clk) disable iff (!resetn)
        rvalid |-> $past(load_pop))
        else $error("rvalid without a load pop in the previous cycle");

endmodule

bind lsu_top lsu_sva u_lsu_sva (
    .clk          (clk),
    .resetn       (resetn),
    .ent_valid    (ent_valid),
    .resp_credit  (resp_credit),
    .issue_credit (issue_credit),
    .mem_en       (mem_en),
    .mem_we       (mem_we),
    .rvalid       (resp_valid)
);

// ==== bench/lsu_tb.sv ====
// Directed testbench for the load/store unit with a byte-level reference memory model
`timescale 1ns/1ps

module lsu_tb;

    localparam int QUEUE_DEPTH = 4;
    localparam int MEM_WORDS   = 256;
    localparam int MEM_BYTES   = MEM_WORDS * 4;
    localparam int WAIT_LIMIT  = 200;

    logic                    clk;
    logic                    resetn;
    logic                    req_valid;
    common_pkg::decoded_op_t op;
    common_pkg::word_t       src1;
    common_pkg::word_t       src2;
    common_pkg::word_t       store_data;
    logic                    issue_credit;
    logic                    resp_credit;
    logic                    resp_valid;
    common_pkg::word_t       load_data;

    logic [7:0]        ref_mem [MEM_BYTES];
    common_pkg::word_t exp_q [$];
    common_pkg::word_t got_q [$];
    logic [31:0]       rng_state;
    int                issued;
    int                returned = 0;
    int                errors;
    int                tests;

    clk_gen u_clk_gen (
        .clk    (clk),
        .resetn (resetn)
    );

    lsu_top #(
        .QUEUE_DEPTH (QUEUE_DEPTH),
        .MEM_WORDS   (MEM_WORDS)
    ) dut (
        .clk          (clk),
        .resetn       (resetn),
        .req_valid    (req_valid),
        .op           (op),
        .src1         (src1),
        .src2         (src2),
        .store_data   (store_data),
        .issue_credit (issue_credit),
        .resp_credit  (resp_credit),
        .resp_valid   (resp_valid),
        .load_data    (load_data)
    );

    // Returned credits and load responses, sampled at the edge that ends the cycle
    always @(posedge clk) begin
        if (resetn) begin
            if (issue_credit) begin
                returned = returned + 1;
            end
            if (resp_valid) begin
                got_q.push_back(load_data);
            end
        end
    end

    function automatic logic [31:0] next_random();
        logic [31:0] x;
        x = rng_state;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        rng_state = x;
        return x;
    endfunction

    function automatic int access_size(input common_pkg::decoded_op_t kind);
        case (kind)
            common_pkg::LB, common_pkg::LBU, common_pkg::SB: return 1;
            common_pkg::LH, common_pkg::LHU, common_pkg::SH: return 2;
            default: return 4;
        endcase
    endfunction

    function automatic common_pkg::decoded_op_t random_op();
        case (next_random() % 8)
            0: return common_pkg::LB;
            1: return common_pkg::LBU;
            2: return common_pkg::LH;
            3: return common_pkg::LHU;
            4: return common_pkg::LW;
            5: return common_pkg::SB;
            6: return common_pkg::SH;
            default: return common_pkg::SW;
        endcase
    endfunction

    function automatic common_pkg::word_t model_load(input common_pkg::decoded_op_t kind,
                                                     input int addr);
        case (kind)
            common_pkg::LB:  return {{24{ref_mem[addr][7]}}, ref_mem[addr]};
            common_pkg::LBU: return {24'h0, ref_mem[addr]};
            common_pkg::LH:  return {{16{ref_mem[addr+1][7]}}, ref_mem[addr+1], ref_mem[addr]};
            common_pkg::LHU: return {16'h0, ref_mem[addr+1], ref_mem[addr]};
            default: return {ref_mem[addr+3], ref_mem[addr+2], ref_mem[addr+1], ref_mem[addr]};
        endcase
    endfunction

    // Stores update the model, loads queue their expected result
    task automatic apply_to_model(input common_pkg::decoded_op_t kind, input int addr,
                                  input common_pkg::word_t data);
        case (kind)
            common_pkg::SB, common_pkg::SH, common_pkg::SW: begin
                for (int b = 0; b < access_size(kind); b++) begin
                    ref_mem[addr+b] = data[8*b +: 8];
                end
            end
            default: begin
                exp_q.push_back(model_load(kind, addr));
            end
        endcase
    endtask

    task automatic issue_op(input common_pkg::decoded_op_t kind, input int addr,
                            input common_pkg::word_t data);
        int                waited;
        common_pkg::word_t split;
        waited = 0;
        while ((QUEUE_DEPTH - issued + returned) == 0 && waited < WAIT_LIMIT) begin
            @(negedge clk);
            waited++;
        end
        if ((QUEUE_DEPTH - issued + returned) == 0) begin
            $display("Timed out waiting for an issue credit");
            errors++;
        end else begin
            split      = next_random();
            req_valid  = 1'b1;
            op         = kind;
            src1       = split;
            src2       = common_pkg::word_t'(addr) - split;
            store_data = data;
            apply_to_model(kind, addr, data);
            issued++;
            @(negedge clk);
            req_valid = 1'b0;
            op        = common_pkg::NOP;
        end
    endtask

    task automatic grant_responses(input int n);
        repeat (n) begin
            resp_credit = 1'b1;
            @(negedge clk);
        end
        resp_credit = 1'b0;
    endtask

    task automatic collect_responses(input string name, input int n);
        int                waited;
        common_pkg::word_t want;
        common_pkg::word_t got;
        for (int i = 0; i < n; i++) begin
            waited = 0;
            while (got_q.size() == 0 && waited < WAIT_LIMIT) begin
                @(negedge clk);
                waited++;
            end
            if (got_q.size() == 0) begin
                $display("%s: timed out waiting for load response %0d", name, i);
                errors++;
            end else if (exp_q.size() == 0) begin
                $display("%s: a response arrived with no load outstanding", name);
                errors++;
                got_q.delete();
            end else begin
                got  = got_q.pop_front();
                want = exp_q.pop_front();
                if (got !== want) begin
                    $display("[ERROR] %s: expected %h, actual %h", name, want, got);
                    errors++;
                end
            end
        end
    endtask

    task automatic wait_credits_home(input string name);
        int waited;
        waited = 0;
        while (issued != returned && waited < WAIT_LIMIT) begin
            @(negedge clk);
            waited++;
        end
        if (issued != returned) begin
            $display("%s: timed out waiting for all issue credits to return", name);
            errors++;
        end
    endtask

    task automatic end_test(input string name, input int start);
        tests++;
        $display("%s: %0d errors", name, errors - start);
    endtask

    task automatic word_round_trip();
        int start;
        int addrs [8];
        start = errors;
        for (int i = 0; i < 8; i++) begin
            addrs[i] = (next_random() % MEM_WORDS) * 4;
            issue_op(common_pkg::SW, addrs[i], next_random());
        end
        grant_responses(8);
        for (int i = 0; i < 8; i++) begin
            issue_op(common_pkg::LW, addrs[i], 32'h0);
        end
        collect_responses("word round trip", 8);
        wait_credits_home("word round trip");
        end_test("word round trip", start);
    endtask

    task automatic partial_stores();
        int start;
        int base;
        start = errors;
        base  = (next_random() % MEM_WORDS) * 4;
        grant_responses(6);
        issue_op(common_pkg::SW, base, next_random());
        for (int off = 0; off < 4; off++) begin
            issue_op(common_pkg::SB, base + off, next_random());
            issue_op(common_pkg::LW, base, 32'h0);
        end
        for (int off = 0; off < 4; off += 2) begin
            issue_op(common_pkg::SH, base + off, next_random());
            issue_op(common_pkg::LW, base, 32'h0);
        end
        collect_responses("partial stores", 6);
        wait_credits_home("partial stores");
        end_test("partial stores", start);
    endtask

    task automatic load_extension();
        int                start;
        int                base;
        common_pkg::word_t pattern [2];
        start      = errors;
        // Every lane and half seen with its top bit both set and clear
        pattern[0] = 32'h80f1_7f0e;
        pattern[1] = 32'h7f01_80ff;
        base       = (next_random() % (MEM_WORDS - 1)) * 4;
        grant_responses(24);
        for (int w = 0; w < 2; w++) begin
            issue_op(common_pkg::SW, base + 4 * w, pattern[w]);
            for (int off = 0; off < 4; off++) begin
                issue_op(common_pkg::LB, base + 4 * w + off, 32'h0);
                issue_op(common_pkg::LBU, base + 4 * w + off, 32'h0);
            end
            for (int off = 0; off < 4; off += 2) begin
                issue_op(common_pkg::LH, base + 4 * w + off, 32'h0);
                issue_op(common_pkg::LHU, base + 4 * w + off, 32'h0);
            end
        end
        collect_responses("load extension", 24);
        wait_credits_home("load extension");
        end_test("load extension", start);
    endtask

    task automatic response_backpressure();
        int start;
        int base;
        start = errors;
        base  = (next_random() % (MEM_WORDS - 2)) * 4;
        for (int i = 0; i < 3; i++) begin
            issue_op(common_pkg::SW, base + 4 * i, next_random());
        end
        for (int i = 0; i < 3; i++) begin
            issue_op(common_pkg::LW, base + 4 * i, 32'h0);
        end
        repeat (20) @(negedge clk);
        if (got_q.size() != 0) begin
            $display("[ERROR] response backpressure: expected %0d, actual %0d", 0, got_q.size());
            errors++;
        end
        for (int i = 0; i < 3; i++) begin
            grant_responses(1);
            collect_responses("response backpressure", 1);
            repeat (5) @(negedge clk);
            if (got_q.size() != 0) begin
                $display("[ERROR] response backpressure: expected %0d, actual %0d",
                         0, got_q.size());
                errors++;
                got_q.delete();
            end
        end
        wait_credits_home("response backpressure");
        end_test("response backpressure", start);
    endtask

    task automatic issue_credit_return();
        int start;
        int base_iss;
        int base_ret;
        start = errors;
        wait_credits_home("issue credits");
        base_iss = issued;
        base_ret = returned;
        for (int i = 0; i < QUEUE_DEPTH; i++) begin
            issue_op(common_pkg::LW, (next_random() % MEM_WORDS) * 4, 32'h0);
        end
        repeat (20) @(negedge clk);
        if (returned != base_ret) begin
            $display("[ERROR] issue credits: expected %0d, actual %0d", 0, returned - base_ret);
            errors++;
        end
        grant_responses(QUEUE_DEPTH);
        collect_responses("issue credits", QUEUE_DEPTH);
        wait_credits_home("issue credits");
        repeat (10) @(negedge clk);
        if ((returned - base_ret) != (issued - base_iss)) begin
            $display("[ERROR] issue credits: expected %0d, actual %0d",
                     issued - base_iss, returned - base_ret);
            errors++;
        end
        end_test("issue credits", start);
    endtask

    task automatic ordering_mix();
        int                      start;
        int                      loads;
        int                      a;
        int                      addrs [40];
        common_pkg::decoded_op_t kinds [40];
        start = errors;
        loads = 0;
        // Small region so stores and loads alias often
        for (int i = 0; i < 40; i++) begin
            kinds[i] = random_op();
            a        = next_random() % 64;
            addrs[i] = 512 + a - (a % access_size(kinds[i]));
            if (access_size(kinds[i]) == 4 || kinds[i] == common_pkg::LB ||
                kinds[i] == common_pkg::LBU || kinds[i] == common_pkg::LH ||
                kinds[i] == common_pkg::LHU) begin
                loads += (kinds[i] == common_pkg::SW) ? 0 : 1;
            end
        end
        grant_responses(loads);
        for (int i = 0; i < 40; i++) begin
            issue_op(kinds[i], addrs[i], next_random());
        end
        collect_responses("ordering mix", loads);
        wait_credits_home("ordering mix");
        end_test("ordering mix", start);
    endtask

    initial begin
        int waited;
        req_valid   = 1'b0;
        op          = common_pkg::NOP;
        src1        = '0;
        src2        = '0;
        store_data  = '0;
        resp_credit = 1'b0;
        rng_state   = 32'd38453;
        issued      = 0;
        errors      = 0;
        tests       = 0;
        waited      = 0;
        for (int i = 0; i < MEM_BYTES; i++) begin
            ref_mem[i] = 8'h00;
        end
        while (resetn !== 1'b1 && waited < 10) begin
            @(negedge clk);
            waited++;
        end
        if (resetn !== 1'b1) begin
            $display("Reset was never released");
            errors++;
        end
        @(negedge clk);
        word_round_trip();
        partial_stores();
        load_extension();
        response_backpressure();
        issue_credit_return();
        ordering_mix();
        $display("Tests run: %0d, errors: %0d", tests, errors);
        if (errors == 0) begin
            $display("Regression passed");
        end else begin
            $display("Regression failed");
        end
        $finish;
    end

endmodule

// ==== filelist.f ====
hdl/common_pkg.sv
hdl/mem_pkg.sv
hdl/writedata.sv
hdl/agu.sv
hdl/lsu_queue.sv
hdl/dmem.sv
hdl/readdata.sv
hdl/lsu_top.sv
bench/clk_gen.sv
bench/lsu_sva.sv
bench/lsu_tb.sv

// ==== run.sh ====
#!/bin/sh
# Builds the LSU testbench with Verilator and runs it

cd "$(dirname "$0")" || exit 1

if ! verilator --binary --timing --assert --top-module lsu_tb -f filelist.f; then
    echo "Verilator build failed"
    exit 1
fi

if ! out=$(./obj_dir/Vlsu_tb 2>&1); then
    printf '%s\n' "$out"
    echo "Simulation exited with an error"
    exit 1
fi

printf '%s\n' "$out"

if printf '%s\n' "$out" | grep -qx "Regression passed"; then
    exit 0
fi
exit 1
